// ==== source/slink_pkg.sv ====
/*
  Shared sizes, opcodes and frame layouts of the serial link.
  Every RTL block takes these by a wildcard import.
*/

`default_nettype none

package slink_pkg;

  //////////////////////////////////////////////////
  // Link sizes
  //////////////////////////////////////////////////

  localparam int unsigned NumLanes     = 4;
  localparam int unsigned ClkDiv       = 2;
  localparam int unsigned AddrWidth    = 6;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned StatusWidth  = 6;
  localparam int unsigned FrameWidth   = 40;
  localparam int unsigned NumBeats     = FrameWidth / NumLanes;
  localparam int unsigned NumWords     = 2 ** AddrWidth;
  localparam int unsigned BeatCntWidth = $clog2(NumBeats + 1);
  localparam int unsigned DivCntWidth  = (ClkDiv > 1) ? $clog2(ClkDiv) : 1;

  //////////////////////////////////////////////////
  // Frame types
  //////////////////////////////////////////////////

  // op_idle never travels in a valid frame
  typedef enum logic [1:0] {
    op_idle  = 2'd0,
    op_read  = 2'd1,
    op_write = 2'd2,
    op_rsp   = 2'd3
  } slink_op_e;

  typedef struct packed {
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } slink_req_t;

  typedef struct packed {
    slink_op_e            op;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
  } slink_req_frame_t;

  // Status bit 0 flags an error
  typedef struct packed {
    slink_op_e              op;
    logic [StatusWidth-1:0] status;
    logic [DataWidth-1:0]   data;
  } slink_rsp_frame_t;

  // Same 40 bits seen as request or response
  typedef union packed {
    slink_req_frame_t req;
    slink_rsp_frame_t rsp;
  } slink_frame_u;

  typedef struct packed {
    logic [NumLanes-1:0] beat;
    logic                strobe;
  } slink_lanes_t;

endpackage

`default_nettype wire

// ==== source/slink_tx.sv ====
/*
  Link serializer. Takes one frame on tx_start_i and sends it MSB first,
  NumLanes bits per beat, one beat every ClkDiv cycles.
  The strobe toggles with every new beat.
*/

`timescale 1ns/10ps
`default_nettype none

module slink_tx import slink_pkg::*; (
  input  wire logic         clk_i,
  input  wire logic         rst_n_i,
  input  wire logic         tx_start_i,
  input  wire slink_frame_u tx_frame_i,
  output logic              tx_busy_o,
  output slink_lanes_t      lanes_o
);

  logic [FrameWidth-1:0]   frame_bits;
  logic [FrameWidth-1:0]   shift_q;
  logic [BeatCntWidth-1:0] beat_cnt_q;
  logic [DivCntWidth-1:0]  div_cnt_q;
  logic                    busy_q;
  slink_lanes_t            lanes_q;
  logic                    load;
  logic                    div_wrap;
  logic                    last_beat;

  assign frame_bits = tx_frame_i;
  assign load       = tx_start_i && !busy_q;
  assign div_wrap   = div_cnt_q == DivCntWidth'(ClkDiv - 1);
  assign last_beat  = beat_cnt_q == BeatCntWidth'(NumBeats);

  // Control and lane registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
      div_cnt_q  <= '0;
      lanes_q    <= '0;
    end else if (load) begin
      busy_q         <= 1'b1;
      beat_cnt_q     <= BeatCntWidth'(1);
      div_cnt_q      <= '0;
      lanes_q.beat   <= frame_bits[FrameWidth-1 -: NumLanes];
      lanes_q.strobe <= ~lanes_q.strobe;
    end else if (busy_q) begin
      if (div_wrap) begin
        div_cnt_q <= '0;
        // Last beat has been held long enough
        if (last_beat) begin
          busy_q <= 1'b0;
        end else begin
          beat_cnt_q     <= beat_cnt_q + 1'b1;
          lanes_q.beat   <= shift_q[FrameWidth-1 -: NumLanes];
          lanes_q.strobe <= ~lanes_q.strobe;
        end
      end else begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  // Remaining beats with the next one on top
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= frame_bits << NumLanes;
    end else if (busy_q && div_wrap && !last_beat) begin
      shift_q <= shift_q << NumLanes;
    end
  end

  assign tx_busy_o = busy_q;
  assign lanes_o   = lanes_q;

endmodule

`default_nettype wire

// ==== source/slink_rx.sv ====
/*
  Link deserializer. Registers the lanes, takes a beat on every strobe
  toggle and pulses frame_valid_o once NumBeats beats are collected.
*/

`timescale 1ns/10ps
`default_nettype none

module slink_rx import slink_pkg::*; (
  input  wire logic         clk_i,
  input  wire logic         rst_n_i,
  input  wire slink_lanes_t lanes_i,
  output logic              frame_valid_o,
  output slink_frame_u      frame_o
);

  slink_lanes_t            lanes_q;
  logic                    strobe_prev_q;
  logic [BeatCntWidth-1:0] beat_cnt_q;
  logic                    valid_q;
  logic [FrameWidth-1:0]   shift_q;
  logic                    toggle;
  logic                    frame_done;

  // A beat is valid when the strobe changed
  assign toggle     = lanes_q.strobe != strobe_prev_q;
  assign frame_done = beat_cnt_q == BeatCntWidth'(NumBeats - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lanes_q       <= '0;
      strobe_prev_q <= 1'b0;
      beat_cnt_q    <= '0;
      valid_q       <= 1'b0;
    end else begin
      lanes_q       <= lanes_i;
      strobe_prev_q <= lanes_q.strobe;
      valid_q       <= toggle && frame_done;
      if (toggle) begin
        beat_cnt_q <= frame_done ? '0 : beat_cnt_q + 1'b1;
      end
    end
  end

  // Beats enter at the bottom so the first one ends up on top
  always_ff @(posedge clk_i) begin
    if (toggle) begin
      shift_q <= {shift_q[FrameWidth-NumLanes-1:0], lanes_q.beat};
    end
  end

  assign frame_valid_o = valid_q;
  assign frame_o       = shift_q;

endmodule

`default_nettype wire

// ==== source/slink_ctrl.sv ====
/*
  Host endpoint of the link. Accepts one request at a time, sends it as a
  request frame and turns the returned frame into a one-cycle response.
  busy_o stays high while a request is in flight.
*/

`timescale 1ns/10ps
`default_nettype none

module slink_ctrl import slink_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 req_valid_i,
  input  wire slink_req_t           req_i,
  output logic                      busy_o,
  output logic                      rsp_valid_o,
  output logic [DataWidth-1:0]      rsp_data_o,
  output logic                      rsp_err_o,
  output slink_lanes_t              lanes_o,
  input  wire slink_lanes_t         lanes_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_wait
  } ctrl_state_e;

  ctrl_state_e          state_q;
  logic                 rsp_valid_q;
  logic [DataWidth-1:0] rsp_data_q;
  logic                 rsp_err_q;
  logic                 accept;
  logic                 tx_busy;
  slink_frame_u         tx_frame;
  logic                 rx_valid;
  slink_frame_u         rx_frame;

  assign accept = (state_q == st_idle) && req_valid_i;

  // Request view of the outgoing frame
  always_comb begin
    tx_frame          = '0;
    tx_frame.req.op   = req_i.write ? op_write : op_read;
    tx_frame.req.addr = req_i.addr;
    tx_frame.req.data = req_i.wdata;
  end

  //////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= st_idle;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        st_idle: if (accept) state_q <= st_send;
        st_send: if (!tx_busy) state_q <= st_wait;
        st_wait: begin
          if (rx_valid) begin
            rsp_valid_q <= 1'b1;
            state_q     <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Response payload read through the response view
  always_ff @(posedge clk_i) begin
    if (rx_valid) begin
      rsp_data_q <= rx_frame.rsp.data;
      rsp_err_q  <= (rx_frame.rsp.op != op_rsp) || rx_frame.rsp.status[0];
    end
  end

  assign busy_o      = state_q != st_idle;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;
  assign rsp_err_o   = rsp_err_q;

  //////////////////////////////////////////////////
  // Link ports
  //////////////////////////////////////////////////

  slink_tx i_tx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .tx_start_i(accept),
    .tx_frame_i(tx_frame),
    .tx_busy_o (tx_busy),
    .lanes_o   (lanes_o)
  );

  slink_rx i_rx (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lanes_i      (lanes_i),
    .frame_valid_o(rx_valid),
    .frame_o      (rx_frame)
  );

endmodule

`default_nettype wire

// ==== source/slink_mem_node.sv ====
/*
  Memory endpoint of the link. Decodes each request frame, reads or
  writes its word array and answers with one response frame.
*/

`timescale 1ns/10ps
`default_nettype none

module slink_mem_node import slink_pkg::*; (
  input  wire logic         clk_i,
  input  wire logic         rst_n_i,
  input  wire slink_lanes_t lanes_i,
  output slink_lanes_t      lanes_o
);

  logic [DataWidth-1:0] mem_q [NumWords];
  logic                 rx_valid;
  slink_frame_u         rx_frame;
  slink_rsp_frame_t     rsp_d;
  slink_frame_u         rsp_q;
  logic                 start_q;
  logic                 wr_en;

  assign wr_en = rx_valid && (rx_frame.req.op == op_write);

  // Answer to the incoming request
  always_comb begin
    rsp_d    = '0;
    rsp_d.op = op_rsp;
    case (rx_frame.req.op)
      op_read:  rsp_d.data = mem_q[rx_frame.req.addr];
      op_write: rsp_d.data = '0;
      default:  rsp_d.status[0] = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////
  // Word array and response launch
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_q <= '{default: '0};
    end else if (wr_en) begin
      mem_q[rx_frame.req.addr] <= rx_frame.req.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= rx_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_valid) begin
      rsp_q.rsp <= rsp_d;
    end
  end

  slink_rx i_rx (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lanes_i      (lanes_i),
    .frame_valid_o(rx_valid),
    .frame_o      (rx_frame)
  );

  // Response sender, started one cycle after a complete request
  slink_tx i_tx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .tx_start_i(start_q),
    .tx_frame_i(rsp_q),
    .tx_busy_o (),
    .lanes_o   (lanes_o)
  );

endmodule

`default_nettype wire

// ==== source/slink_top.sv ====
/*
  Link top level with the host endpoint and the memory endpoint.
  Both lane bundles leave the chip and are cross-connected outside.
*/

`timescale 1ns/10ps
`default_nettype none

module slink_top import slink_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,

  // Host request and response
  input  wire logic                 req_valid_i,
  input  wire slink_req_t           req_i,
  output logic                      busy_o,
  output logic                      rsp_valid_o,
  output logic [DataWidth-1:0]      rsp_data_o,
  output logic                      rsp_err_o,

  // Lanes of both endpoints
  output slink_lanes_t              host_lanes_o,
  input  wire slink_lanes_t         host_lanes_i,
  output slink_lanes_t              mem_lanes_o,
  input  wire slink_lanes_t         mem_lanes_i
);

  //////////////////////////////////////////////////
  // Host endpoint
  //////////////////////////////////////////////////

  slink_ctrl i_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_i),
    .req_i      (req_i),
    .busy_o     (busy_o),
    .rsp_valid_o(rsp_valid_o),
    .rsp_data_o (rsp_data_o),
    .rsp_err_o  (rsp_err_o),
    .lanes_o    (host_lanes_o),
    .lanes_i    (host_lanes_i)
  );

  //////////////////////////////////////////////////
  // Memory endpoint
  //////////////////////////////////////////////////

  slink_mem_node i_mem_node (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .lanes_i(mem_lanes_i),
    .lanes_o(mem_lanes_o)
  );

endmodule

`default_nettype wire

// ==== tb/slink_props.sv ====
/*
  Protocol assertions for the link top level, bound into slink_top.
  Covers the response pulse, the busy window and the host strobe.
*/

`timescale 1ns/10ps
`default_nettype none

module slink_props import slink_pkg::*; (
  input wire logic         clk_i,
  input wire logic         rst_n_i,
  input wire logic         req_valid_i,
  input wire logic         busy_o,
  input wire logic         rsp_valid_o,
  input wire slink_lanes_t host_lanes_o
);

  // Response is a single-cycle pulse
  rsp_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |=> !rsp_valid_o)
    else $error("rsp_valid_o high for more than one cycle");

  // Accepted request raises busy on the next cycle
  busy_start_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_valid_i && !busy_o) |=> busy_o)
    else $error("busy_o low after an accepted request");

  busy_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_o |=> (busy_o || rsp_valid_o))
    else $error("busy_o dropped before rsp_valid_o");

  busy_end_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> !busy_o)
    else $error("busy_o still high during rsp_valid_o");

  // Host link is quiet while idle
  strobe_idle_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy_o |-> $stable(host_lanes_o.strobe))
    else $error("host strobe toggled while busy_o was low");

endmodule

`default_nettype wire

// ==== tb/tb_slink_top.sv ====
/*
  Testbench for the serial link top level. Cross-connects both lane
  bundles, runs single-word reads and writes against a reference memory
  and checks every response. Protocol rules come from the bound props.
*/

`timescale 1ns/10ps
`default_nettype none

module tb_slink_top import slink_pkg::*; ();

  localparam int unsigned RspTimeout  = 200;
  localparam int unsigned QuietCycles = 120;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 req_valid_i;
  slink_req_t           req_i;
  logic                 busy_o;
  logic                 rsp_valid_o;
  logic [DataWidth-1:0] rsp_data_o;
  logic                 rsp_err_o;
  slink_lanes_t         host_lanes;
  slink_lanes_t         mem_lanes;
  logic [DataWidth-1:0] ref_mem [NumWords];
  int                   seed;

  // Host lanes feed the memory node and the other way round
  slink_top i_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_err_o   (rsp_err_o),
    .host_lanes_o(host_lanes),
    .host_lanes_i(mem_lanes),
    .mem_lanes_o (mem_lanes),
    .mem_lanes_i (host_lanes)
  );

  bind slink_top slink_props i_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .host_lanes_o(host_lanes_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  // One-cycle request pulse
  task automatic send_request(input logic wr, input logic [AddrWidth-1:0] addr,
                              input logic [DataWidth-1:0] data);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i.write <= wr;
    req_i.addr  <= addr;
    req_i.wdata <= data;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  // Sampled on the falling edge where outputs are settled
  task automatic wait_response(output logic [DataWidth-1:0] data, output logic err);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (rsp_valid_o !== 1'b1) begin
      if (cycles == RspTimeout) begin
        $display("Timeout: no rsp_valid_o within %0d cycles", RspTimeout);
        abort_run();
      end
      @(negedge clk_i);
      cycles++;
    end
    data = rsp_data_o;
    err  = rsp_err_o;
  endtask

  task automatic compare_response(input logic [DataWidth-1:0] got, input logic got_err,
                                  input logic [DataWidth-1:0] exp);
    assert (got === exp) else begin
      $display("error: rsp_data_o = %h, expected %h", got, exp);
      abort_run();
    end
    assert (got_err === 1'b0) else begin
      $display("error: rsp_err_o = %h, expected %h", got_err, 1'b0);
      abort_run();
    end
  endtask

  // Writes answer with zero data, reads with the model word
  task automatic transact(input logic wr, input logic [AddrWidth-1:0] addr,
                          input logic [DataWidth-1:0] data);
    logic [DataWidth-1:0] got;
    logic                 got_err;
    logic [DataWidth-1:0] exp;
    exp = wr ? '0 : ref_mem[addr];
    send_request(wr, addr, data);
    wait_response(got, got_err);
    compare_response(got, got_err, exp);
    if (wr) begin
      ref_mem[addr] = data;
    end
  endtask

  // Second write lands while busy and must leave no trace
  task automatic drop_busy_request(input logic [AddrWidth-1:0] addr);
    logic [DataWidth-1:0] first;
    logic [DataWidth-1:0] got;
    logic                 got_err;
    int unsigned          pulses;
    first = $random(seed);
    send_request(1'b1, addr, first);
    // Host frame is out, only the response is still pending
    repeat (NumBeats * ClkDiv) @(posedge clk_i);
    @(negedge clk_i);
    assert (busy_o === 1'b1) else begin
      $display("busy_o was low when the second request was due");
      abort_run();
    end
    send_request(1'b1, addr, ~first);
    wait_response(got, got_err);
    compare_response(got, got_err, '0);
    ref_mem[addr] = first;
    pulses = 0;
    for (int unsigned i = 0; i < QuietCycles; i++) begin
      @(negedge clk_i);
      if (rsp_valid_o === 1'b1) begin
        pulses++;
      end
    end
    assert (pulses == 0) else begin
      $display("A response followed the request sent while busy_o was high");
      abort_run();
    end
    transact(1'b0, addr, '0);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]          rnd;
    logic [AddrWidth-1:0] addr;
    rst_n_i     <= 1'b0;
    req_valid_i <= 1'b0;
    req_i       <= '0;
    seed = 32'h6fcd;
    for (int i = 0; i < NumWords; i++) begin
      ref_mem[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Fresh memory reads back zero
    for (int i = 0; i < 5; i++) begin
      rnd = $random(seed);
      transact(1'b0, rnd[AddrWidth-1:0], '0);
    end

    // Write then read the same word
    rnd = $random(seed);
    transact(1'b1, 6'd21, rnd);
    transact(1'b0, 6'd21, '0);

    // Small address range so words get overwritten
    for (int i = 0; i < 40; i++) begin
      rnd  = $random(seed);
      addr = {2'b00, rnd[3:0]};
      transact(rnd[31], addr, $random(seed));
    end
    for (int i = 0; i < 16; i++) begin
      transact(1'b0, 6'(i), '0);
    end

    drop_busy_request(6'd40);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== slink_top.f ====
source/slink_pkg.sv
source/slink_tx.sv
source/slink_rx.sv
source/slink_ctrl.sv
source/slink_mem_node.sv
source/slink_top.sv
tb/slink_props.sv
tb/tb_slink_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the link regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_slink_top \
  --Mdir obj_dir -o Vtb_slink_top \
  -f slink_top.f

status=0
./obj_dir/Vtb_slink_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Regression passed" sim.log; then
  echo "Simulation stopped before the end"
  exit 1
fi
echo "Simulation completed"
